// ==== Bender.yml ====
package:
  name: l1_cache

export_include_dirs:
  - .

sources:
  - files:
      - cache_geom_pkg.sv
      - cache_ctrl_pkg.sv
      - cache_way.sv
      - way_select.sv
      - cache_ctrl.sv
      - l1_cache.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_l1_cache.sv

// ==== cache_consts.svh ====
/* geometry of the L1 data cache, shared by the packages and the RTL
   set and block counts must stay powers of two; the design is built for two ways */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// data word, bits
`define L1_WORD_W 32

// sets per way
`define L1_N_SETS 16

// words in one cache block
`define L1_BLOCK_WORDS 2

// ways per set, LRU is a single bit per set
`define L1_ASSOC 2

// everything from here up bypasses the cache
`define L1_NONCACHE_BASE 32'h8000_0000

`endif

// ==== cache_ctrl.sv ====
/* miss FSM, memory-side sequencing and pass-through for the L1 cache
   processor must hold its request until proc_busy is low; only one miss at a time */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_ctrl
    import cache_geom_pkg::*, cache_ctrl_pkg::*;
(
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         proc_ren,
    input  logic                         proc_wen,
    input  addr_t                        proc_addr,
    input  word_t                        proc_wdata,
    input  byte_en_t                     proc_byte_en,
    output word_t                        proc_rdata,
    output logic                         proc_busy,
    output logic                         mem_ren,
    output logic                         mem_wen,
    output addr_t                        mem_addr,
    output word_t                        mem_wdata,
    output byte_en_t                     mem_byte_en,
    input  word_t                        mem_rdata,
    input  logic                         mem_busy,
    input  logic                         any_hit,
    input  way_idx_t                     hit_way,
    input  word_t                        hit_data,
    input  way_idx_t                     victim_way,
    input  logic                         victim_dirty,
    input  tag_t                         victim_tag,
    input  word_t [`L1_BLOCK_WORDS-1:0]  victim_data,
    output set_idx_t                     set_idx,
    output tag_t                         lookup_tag,
    output blk_off_t                     blk_off,
    output logic [`L1_ASSOC-1:0]         wr_word_en,
    output blk_off_t                     wr_word_idx,
    output word_t                        wr_data,
    output byte_en_t                     wr_byte_en,
    output logic [`L1_ASSOC-1:0]         set_dirty,
    output logic [`L1_ASSOC-1:0]         clr_dirty,
    output logic [`L1_ASSOC-1:0]         install_en,
    output tag_t                         install_tag,
    output logic                         lru_touch,
    output way_idx_t                     touch_way
);

    ctrl_state_t state, next_state;
    blk_off_t    word_cnt, next_word_cnt;  // word of the block on the memory bus
    addr_t       blk_addr, next_blk_addr;  // current memory word address
    addr_t       fill_base, wb_base;
    logic        req, pass_through, last_word;
    word_t       pt_wdata;

    // address fields of the held request
    assign lookup_tag  = proc_addr[`L1_WORD_W-1 -: TAG_W];
    assign set_idx     = proc_addr[OFF_W+2 +: SET_W];
    assign blk_off     = proc_addr[2 +: OFF_W];
    assign install_tag = lookup_tag;

    assign fill_base = {lookup_tag, set_idx, {OFF_W{1'b0}}, 2'b00};
    assign wb_base   = {victim_tag, set_idx, {OFF_W{1'b0}}, 2'b00};

    assign req          = proc_ren || proc_wen;
    assign pass_through = (proc_addr >= `L1_NONCACHE_BASE);
    assign last_word    = (word_cnt == blk_off_t'(`L1_BLOCK_WORDS-1));

    // uncached write data with disabled lanes forced to zero
    always_comb begin
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            pt_wdata[8*b +: 8] = proc_byte_en[b] ? proc_wdata[8*b +: 8] : 8'h00;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            blk_addr <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            blk_addr <= next_blk_addr;
        end
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        next_blk_addr = blk_addr;
        proc_busy     = 1'b1;
        proc_rdata    = hit_data;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_addr      = blk_addr;
        mem_wdata     = '0;
        mem_byte_en   = '1;  // block traffic is always full words
        wr_word_en    = '0;
        wr_word_idx   = blk_off;
        wr_data       = proc_wdata;
        wr_byte_en    = proc_byte_en;
        set_dirty     = '0;
        clr_dirty     = '0;
        install_en    = '0;
        lru_touch     = 1'b0;
        touch_way     = hit_way;

        case (state)
            IDLE: begin
                if (req && pass_through) begin
                    mem_ren     = proc_ren && !proc_wen;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_wdata   = pt_wdata;
                    mem_byte_en = proc_byte_en;
                    proc_busy   = mem_busy;  // done when memory is
                    proc_rdata  = mem_rdata;
                end else if (req && any_hit) begin
                    proc_busy = 1'b0;
                    lru_touch = 1'b1;
                    if (proc_wen) begin
                        wr_word_en[hit_way] = 1'b1;
                        set_dirty[hit_way]  = 1'b1;
                    end
                end else if (req) begin
                    next_word_cnt = '0;
                    if (victim_dirty) begin
                        next_state    = WRITEBACK;
                        next_blk_addr = wb_base;
                    end else begin
                        next_state    = FETCH;
                        next_blk_addr = fill_base;
                    end
                end
            end

            WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_wdata = victim_data[word_cnt];
                if (!mem_busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    next_blk_addr = blk_addr + 32'd4;
                    if (last_word) begin
                        clr_dirty[victim_way] = 1'b1;
                        next_state            = FETCH;
                        next_blk_addr         = fill_base;
                    end
                end
            end

            FETCH: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    wr_word_en[victim_way] = 1'b1;  // fill lands in the victim way
                    wr_word_idx            = word_cnt;
                    wr_data                = mem_rdata;
                    wr_byte_en             = '1;
                    next_word_cnt          = word_cnt + 1'b1;
                    next_blk_addr          = blk_addr + 32'd4;
                    if (last_word) begin
                        next_state = INSTALL;
                    end
                end
            end

            INSTALL: begin
                install_en[victim_way] = 1'b1;
                next_state             = IDLE;  // request hits next cycle
            end

            default: next_state = IDLE;
        endcase
    end

    a_ren_wen_excl: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen)
    );

endmodule

// ==== cache_ctrl_pkg.sv ====
/* controller state and way numbering
   way_idx_t covers L1_ASSOC ways */
`include "cache_consts.svh"

package cache_ctrl_pkg;

    // miss handling sequence
    typedef enum logic [1:0] {
        IDLE,       // lookup, hits and pass-through
        WRITEBACK,  // dirty victim out to memory
        FETCH,      // missing block in from memory
        INSTALL     // new tag and valid
    } ctrl_state_t;

    typedef logic [$clog2(`L1_ASSOC)-1:0] way_idx_t;

endpackage

// ==== cache_geom_pkg.sv ====
/* address split and data types of the cache
   byte address = {tag, set index, block offset, 2 byte bits} */
`include "cache_consts.svh"

package cache_geom_pkg;

    // field widths derived from the geometry macros
    localparam int SET_W = $clog2(`L1_N_SETS);
    localparam int OFF_W = $clog2(`L1_BLOCK_WORDS);
    localparam int TAG_W = `L1_WORD_W - SET_W - OFF_W - 2;

    typedef logic [`L1_WORD_W-1:0]   word_t;
    typedef logic [`L1_WORD_W-1:0]   addr_t;     // byte address
    typedef logic [`L1_WORD_W/8-1:0] byte_en_t;  // one bit per byte lane

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [OFF_W-1:0] blk_off_t;  // word within a block

endpackage

// ==== cache_way.sv ====
/* one cache way: valid, dirty, tag and data per set, read combinationally
   install wins over dirty updates in the same cycle; data writes honour byte enables */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_way
    import cache_geom_pkg::*;
(
    input  logic                         CLK,
    input  logic                         nRST,
    input  set_idx_t                     set_idx,
    input  tag_t                         lookup_tag,
    input  logic                         wr_word_en,
    input  blk_off_t                     wr_word_idx,
    input  word_t                        wr_data,
    input  byte_en_t                     wr_byte_en,
    input  logic                         set_dirty,
    input  logic                         clr_dirty,
    input  logic                         install_en,
    input  tag_t                         install_tag,
    output logic                         hit,
    output logic                         line_valid,
    output logic                         line_dirty,
    output tag_t                         line_tag,
    output word_t [`L1_BLOCK_WORDS-1:0]  line_data
);

    logic [`L1_N_SETS-1:0]       valid_q;
    logic [`L1_N_SETS-1:0]       dirty_q;
    tag_t                        tag_q  [`L1_N_SETS];
    word_t [`L1_BLOCK_WORDS-1:0] data_q [`L1_N_SETS];

    // line state bits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (install_en) begin
                valid_q[set_idx] <= 1'b1;
                dirty_q[set_idx] <= 1'b0;  // freshly fetched block is clean
            end else if (set_dirty) begin
                dirty_q[set_idx] <= 1'b1;
            end else if (clr_dirty) begin
                dirty_q[set_idx] <= 1'b0;  // after writeback
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge CLK) begin
        if (install_en) begin
            tag_q[set_idx] <= install_tag;
        end
        if (wr_word_en) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (wr_byte_en[b]) begin
                    data_q[set_idx][wr_word_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign line_valid = valid_q[set_idx];
    assign line_dirty = dirty_q[set_idx];
    assign line_tag   = tag_q[set_idx];
    assign line_data  = data_q[set_idx];

    assign hit = line_valid && (line_tag == lookup_tag);

    // install only follows a fetch, never a write hit
    a_install_no_dirty: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(install_en && set_dirty)
    );

endmodule

// ==== l1_cache.f ====
+incdir+.
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

// ==== l1_cache.sv ====
/* write-back, two-way L1 data cache between a processor bus and a memory bus
   requests above L1_NONCACHE_BASE go straight to memory; no flush or clear */
`timescale 1ns/1ps
`include "cache_consts.svh"

module l1_cache
    import cache_geom_pkg::*, cache_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     proc_ren,
    input  logic     proc_wen,
    input  addr_t    proc_addr,
    input  word_t    proc_wdata,
    input  byte_en_t proc_byte_en,
    output word_t    proc_rdata,
    output logic     proc_busy,
    output logic     mem_ren,
    output logic     mem_wen,
    output addr_t    mem_addr,
    output word_t    mem_wdata,
    output byte_en_t mem_byte_en,
    input  word_t    mem_rdata,
    input  logic     mem_busy
);

    // controller to ways
    set_idx_t             set_idx;
    tag_t                 lookup_tag;
    blk_off_t             blk_off;
    logic [`L1_ASSOC-1:0] wr_word_en;
    blk_off_t             wr_word_idx;
    word_t                wr_data;
    byte_en_t             wr_byte_en;
    logic [`L1_ASSOC-1:0] set_dirty;
    logic [`L1_ASSOC-1:0] clr_dirty;
    logic [`L1_ASSOC-1:0] install_en;
    tag_t                 install_tag;

    // ways to selector
    logic [`L1_ASSOC-1:0]        way_hit;
    logic [`L1_ASSOC-1:0]        way_valid;
    logic [`L1_ASSOC-1:0]        way_dirty;
    tag_t                        way_tag  [`L1_ASSOC];
    word_t [`L1_BLOCK_WORDS-1:0] way_data [`L1_ASSOC];

    // selector to controller
    logic                        any_hit;
    way_idx_t                    hit_way;
    word_t                       hit_data;
    way_idx_t                    victim_way;
    logic                        victim_dirty;
    tag_t                        victim_tag;
    word_t [`L1_BLOCK_WORDS-1:0] victim_data;
    logic                        lru_touch;
    way_idx_t                    touch_way;

    cache_ctrl u_ctrl (
        .CLK, .nRST,
        .proc_ren, .proc_wen, .proc_addr, .proc_wdata, .proc_byte_en,
        .proc_rdata, .proc_busy,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en,
        .mem_rdata, .mem_busy,
        .any_hit, .hit_way, .hit_data,
        .victim_way, .victim_dirty, .victim_tag, .victim_data,
        .set_idx, .lookup_tag, .blk_off,
        .wr_word_en, .wr_word_idx, .wr_data, .wr_byte_en,
        .set_dirty, .clr_dirty, .install_en, .install_tag,
        .lru_touch, .touch_way
    );

    for (genvar g = 0; g < `L1_ASSOC; g++) begin : g_way
        cache_way u_way (
            .CLK, .nRST,
            .set_idx, .lookup_tag,
            .wr_word_en (wr_word_en[g]),
            .wr_word_idx, .wr_data, .wr_byte_en,
            .set_dirty  (set_dirty[g]),
            .clr_dirty  (clr_dirty[g]),
            .install_en (install_en[g]),
            .install_tag,
            .hit        (way_hit[g]),
            .line_valid (way_valid[g]),
            .line_dirty (way_dirty[g]),
            .line_tag   (way_tag[g]),
            .line_data  (way_data[g])
        );
    end

    way_select u_sel (
        .CLK, .nRST,
        .set_idx,
        .way_hit, .way_valid, .way_dirty, .way_tag, .way_data,
        .blk_off, .lru_touch, .touch_way,
        .any_hit, .hit_way, .hit_data,
        .victim_way, .victim_dirty, .victim_tag, .victim_data
    );

endmodule

// ==== tb_l1_cache.sv ====
/* testbench for the L1 cache with a shadow memory as reference and random memory stalls
   each request is held until proc_busy is low; concurrent assertions do the checking */
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_l1_cache
    import cache_geom_pkg::*;
();

    localparam int REQ_TIMEOUT = 200;  // cycles per request
    localparam int K_HIT = 1, K_CLEAN = 2, K_DIRTY = 3, K_PT = 4;
    localparam int BLK_BYTES = 4 * `L1_BLOCK_WORDS;

    logic     CLK, nRST;
    logic     proc_ren, proc_wen, proc_busy;
    addr_t    proc_addr;
    word_t    proc_wdata, proc_rdata;
    byte_en_t proc_byte_en;
    logic     mem_ren, mem_wen, mem_busy;
    addr_t    mem_addr;
    word_t    mem_wdata, mem_rdata;
    byte_en_t mem_byte_en;

    // expectations for the request in flight
    logic        started, chk_read, exp_hit, exp_fill, exp_wb, exp_pt;
    word_t       exp_rdata;
    addr_t       exp_fill_base, exp_wb_base;
    word_t       exp_wb_data [`L1_BLOCK_WORDS];
    int unsigned rd_beats, wr_beats, rd_base, wr_base;

    word_t       shadow [addr_t];
    int          err_cnt, err_mark, test_cnt, failed_cnt;
    int unsigned seed;
    word_t       rnd;
    addr_t       a_addr, b_addr, c_addr, p_addr;

    l1_cache u_l1_cache (
        .CLK, .nRST,
        .proc_ren, .proc_wen, .proc_addr, .proc_wdata, .proc_byte_en,
        .proc_rdata, .proc_busy,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en,
        .mem_rdata, .mem_busy
    );

    tb_mem_model u_mem (
        .CLK, .nRST,
        .ren (mem_ren), .wen (mem_wen), .addr (mem_addr),
        .wdata (mem_wdata), .byte_en (mem_byte_en),
        .rdata (mem_rdata), .busy (mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // completed memory words counted at the edge that completes them
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_beats <= 0;
            wr_beats <= 0;
        end else begin
            if (mem_ren && !mem_busy) rd_beats <= rd_beats + 1;
            if (mem_wen && !mem_busy) wr_beats <= wr_beats + 1;
        end
    end

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);  // same rule as the memory
    endfunction

    function automatic word_t shadow_rd(addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return fill_word(a);
    endfunction

    // byte lanes of a word selected by a byte enable
    function automatic word_t lane_mask(byte_en_t be);
        word_t m;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    // {tag, set, word, 2 byte bits}
    function automatic addr_t mk_addr(int tag, int set, int word);
        return addr_t'((tag << 7) | (set << 3) | (word << 2));
    endfunction

    task automatic access(input logic wr, input addr_t a, input word_t wd,
                          input byte_en_t be, input int kind, input addr_t wb_base);
        int    n;
        word_t w;
        @(posedge CLK);
        started      <= 1'b1;
        proc_ren     <= !wr;
        proc_wen     <= wr;
        proc_addr    <= a;
        proc_wdata   <= wd;
        proc_byte_en <= be;
        rd_base      <= rd_beats;
        wr_base      <= wr_beats;
        exp_hit      <= (kind == K_HIT);
        exp_fill     <= (kind == K_CLEAN) || (kind == K_DIRTY);
        exp_wb       <= (kind == K_DIRTY);
        exp_pt       <= (kind == K_PT);
        chk_read     <= !wr;
        exp_rdata    <= shadow_rd(a);
        exp_fill_base <= a & ~addr_t'(BLK_BYTES - 1);
        exp_wb_base  <= wb_base;
        for (int i = 0; i < `L1_BLOCK_WORDS; i++) begin
            exp_wb_data[i] <= shadow_rd(wb_base + 4 * i);
        end
        n = 0;
        @(negedge CLK);
        while (proc_busy && n < REQ_TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (proc_busy) begin
            $display("timeout: request at address %h never saw proc_busy low", a);
            $display(">>> FAIL");
            $finish;
        end
        if (wr) begin
            w = shadow_rd(a);
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (be[b]) w[8*b +: 8] = wd[8*b +: 8];
            end
            shadow[a] = w;
        end
        @(posedge CLK);  // the request completes at this edge
        proc_ren <= 1'b0;
        proc_wen <= 1'b0;
        {exp_hit, exp_fill, exp_wb, exp_pt, chk_read} <= '0;
    endtask

    task automatic report_test(input string name);
        repeat (2) @(negedge CLK);
        test_cnt++;
        if (err_cnt != err_mark) failed_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt != err_mark) ? "failed" : "ok");
        err_mark = err_cnt;
    endtask

    a_quiet_bus: assert property (@(posedge CLK) disable iff (!nRST)
        !started |-> !(mem_ren || mem_wen))
        else begin
            err_cnt++;
            $display("Error: mem_ren %h mem_wen %h before any request",
                     $sampled(mem_ren), $sampled(mem_wen));
        end

    a_read_data: assert property (@(negedge CLK) disable iff (!nRST)
        (chk_read && proc_ren && !proc_busy) |-> proc_rdata == exp_rdata)
        else begin
            err_cnt++;
            $display("Error: proc_rdata got %h expected %h at %h",
                     $sampled(proc_rdata), $sampled(exp_rdata), $sampled(proc_addr));
        end

    a_hit_fast: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_hit && (proc_ren || proc_wen)) |-> !proc_busy && !mem_ren && !mem_wen)
        else begin
            err_cnt++;
            $display("Error: proc_busy %h mem_ren %h mem_wen %h on a hit",
                     $sampled(proc_busy), $sampled(mem_ren), $sampled(mem_wen));
        end

    a_fill_addr: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_fill && mem_ren && !mem_busy)
        |-> mem_addr == exp_fill_base + ((rd_beats - rd_base) << 2))
        else begin
            err_cnt++;
            $display("Error: mem_addr got %h on fill, block base %h",
                     $sampled(mem_addr), $sampled(exp_fill_base));
        end

    a_no_wb: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_fill && !exp_wb) |-> !mem_wen)
        else begin
            err_cnt++;
            $display("Error: mem_wen %h during a clean miss", $sampled(mem_wen));
        end

    a_wb_word: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_wb && mem_wen && !mem_busy)
        |-> mem_addr == exp_wb_base + ((wr_beats - wr_base) << 2)
            && mem_wdata == exp_wb_data[wr_beats - wr_base]
            && rd_beats == rd_base)
        else begin
            err_cnt++;
            $display("Error: writeback mem_addr %h mem_wdata %h, victim base %h",
                     $sampled(mem_addr), $sampled(mem_wdata), $sampled(exp_wb_base));
        end

    a_miss_beats: assert property (@(negedge CLK) disable iff (!nRST)
        (exp_fill && !proc_busy)
        |-> rd_beats - rd_base == `L1_BLOCK_WORDS
            && wr_beats - wr_base == (exp_wb ? `L1_BLOCK_WORDS : 0))
        else begin
            err_cnt++;
            $display("Error: miss took %h memory reads and %h memory writes",
                     $sampled(rd_beats - rd_base), $sampled(wr_beats - wr_base));
        end

    a_pt_bus: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_pt && !proc_busy)
        |-> mem_addr == proc_addr && mem_ren == proc_ren && mem_wen == proc_wen
            && (!proc_ren || proc_rdata == mem_rdata)
            && (!proc_wen || (mem_byte_en == proc_byte_en
                && mem_wdata == (proc_wdata & lane_mask(proc_byte_en)))))
        else begin
            err_cnt++;
            $display("Error: mem_addr %h mem_ren %h mem_wen %h for proc_addr %h",
                     $sampled(mem_addr), $sampled(mem_ren), $sampled(mem_wen),
                     $sampled(proc_addr));
            $display("Error: mem_byte_en %h mem_wdata %h for proc_byte_en %h proc_wdata %h",
                     $sampled(mem_byte_en), $sampled(mem_wdata),
                     $sampled(proc_byte_en), $sampled(proc_wdata));
        end

    a_pt_no_fill: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_pt && !proc_busy) |=> !(mem_ren || mem_wen))
        else begin
            err_cnt++;
            $display("Error: mem_ren %h mem_wen %h after an uncached access",
                     $sampled(mem_ren), $sampled(mem_wen));
        end

    initial begin
        seed = $urandom(32'hf8f32281);
        nRST = 1'b0;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        proc_byte_en = '0;
        {started, chk_read, exp_hit, exp_fill, exp_wb, exp_pt} = '0;
        exp_rdata = '0;
        exp_fill_base = '0;
        exp_wb_base = '0;
        err_cnt = 0;
        err_mark = 0;
        test_cnt = 0;
        failed_cnt = 0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        repeat (4) @(posedge CLK);  // bus stays idle
        access(1'b0, mk_addr(9, 0, 0), '0, '1, K_CLEAN, '0);
        report_test("reset_idle");

        a_addr = mk_addr(4, 1, 1);
        rnd = $urandom;
        access(1'b1, a_addr, rnd, 4'b0101, K_CLEAN, '0);
        access(1'b0, a_addr, '0, '1, K_HIT, '0);
        rnd = $urandom;
        access(1'b1, a_addr, rnd, 4'b1000, K_HIT, '0);
        access(1'b0, a_addr, '0, '1, K_HIT, '0);
        access(1'b0, mk_addr(4, 1, 0), '0, '1, K_HIT, '0);
        report_test("byte_write");

        access(1'b0, mk_addr(7, 2, 1), '0, '1, K_CLEAN, '0);
        access(1'b0, mk_addr(7, 2, 1), '0, '1, K_HIT, '0);
        access(1'b0, mk_addr(7, 2, 0), '0, '1, K_HIT, '0);
        report_test("read_miss_fill");

        a_addr = mk_addr(1, 5, 0);
        b_addr = mk_addr(2, 5, 1);
        c_addr = mk_addr(3, 5, 0);
        rnd = $urandom;
        access(1'b1, a_addr, rnd, 4'b1111, K_CLEAN, '0);
        rnd = $urandom;
        access(1'b1, b_addr, rnd, 4'b0011, K_CLEAN, '0);
        access(1'b0, a_addr, '0, '1, K_HIT, '0);  // b is now least recent
        access(1'b0, c_addr, '0, '1, K_DIRTY, b_addr & ~addr_t'(BLK_BYTES - 1));
        access(1'b0, b_addr, '0, '1, K_DIRTY, a_addr);
        report_test("dirty_evict");

        p_addr = 32'h8000_0010;
        rnd = $urandom;
        access(1'b1, p_addr, rnd, 4'b1111, K_PT, '0);
        access(1'b0, p_addr, '0, '1, K_PT, '0);
        rnd = $urandom;
        access(1'b1, p_addr, rnd, 4'b0110, K_PT, '0);
        access(1'b0, p_addr, '0, '1, K_PT, '0);
        access(1'b0, `L1_NONCACHE_BASE, '0, '1, K_PT, '0);
        report_test("pass_through");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, failed_cnt, err_cnt);
        if (err_cnt == 0 && failed_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
/* word-addressed memory behind the cache's memory bus, unwritten words read a fill pattern
   busy is a registered random stall; writes merge the enabled byte lanes */
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_mem_model
    import cache_geom_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     ren,
    input  logic     wen,
    input  addr_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    output word_t    rdata,
    output logic     busy
);

    word_t       mem [addr_t];  // sparse, keyed by word-aligned address
    int unsigned wr_seq;        // bumps on every write so rdata re-evaluates

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic word_t read_word(addr_t a);
        addr_t key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return fill_word(key);
    endfunction

    always @(posedge CLK or negedge nRST) begin
        word_t w;
        if (!nRST) begin
            busy   <= 1'b0;
            wr_seq <= 0;
        end else begin
            busy <= (($urandom % 4) == 0);  // roughly one stall in four
            if (wen && !busy) begin
                w = read_word(addr);
                for (int b = 0; b < $bits(byte_en_t); b++) begin
                    if (byte_en[b]) w[8*b +: 8] = wdata[8*b +: 8];
                end
                mem[{addr[31:2], 2'b00}] = w;
                wr_seq <= wr_seq + 1;
            end
        end
    end

    always @(addr or wr_seq) begin
        rdata = read_word(addr);
    end

endmodule

// ==== way_select.sv ====
/* hit reduction, data mux and per-set LRU over the ways
   victim prefers an invalid way, else the way not last used (two ways only) */
`timescale 1ns/1ps
`include "cache_consts.svh"

module way_select
    import cache_geom_pkg::*, cache_ctrl_pkg::*;
(
    input  logic                         CLK,
    input  logic                         nRST,
    input  set_idx_t                     set_idx,
    input  logic [`L1_ASSOC-1:0]         way_hit,
    input  logic [`L1_ASSOC-1:0]         way_valid,
    input  logic [`L1_ASSOC-1:0]         way_dirty,
    input  tag_t                         way_tag [`L1_ASSOC],
    input  word_t [`L1_BLOCK_WORDS-1:0]  way_data [`L1_ASSOC],
    input  blk_off_t                     blk_off,
    input  logic                         lru_touch,
    input  way_idx_t                     touch_way,
    output logic                         any_hit,
    output way_idx_t                     hit_way,
    output word_t                        hit_data,
    output way_idx_t                     victim_way,
    output logic                         victim_dirty,
    output tag_t                         victim_tag,
    output word_t [`L1_BLOCK_WORDS-1:0]  victim_data
);

    way_idx_t last_used [`L1_N_SETS];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            last_used <= '{default: '0};
        end else if (lru_touch) begin
            last_used[set_idx] <= touch_way;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L1_ASSOC; w++) begin
            if (way_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign any_hit  = |way_hit;
    assign hit_data = way_data[hit_way][blk_off];

    // lowest invalid way overrides LRU choice
    always_comb begin
        victim_way = ~last_used[set_idx];
        for (int w = `L1_ASSOC-1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    assign victim_dirty = way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];
    assign victim_data  = way_data[victim_way];

    // a block lives in at most one way of its set
    a_one_hit: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0(way_hit)
    );

endmodule
